//--- all.f
logic/lsu_pkg.sv
logic/lsu_issue_queue.sv
logic/load_store_unit.sv
logic/data_mem.sv
logic/lsu_top.sv
testbench/lsu_tb.sv

//--- logic/data_mem.sv
// Data memory
// 256-word synchronous store. One-cycle registered response that holds
// until the client takes it

`timescale 1ns/10ps

module data_mem import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  input  logic      req_val,
  output logic      req_rdy,
  input  mem_req_t  req,

  output logic      resp_val,
  input  logic      resp_rdy,
  output mem_resp_t resp
);

  word_t    mem [MEM_WORDS];
  mem_idx_t idx;
  logic     req_xfer;
  logic     resp_xfer;
  word_t    resp_data;

  // Word index, upper address bits alias
  assign idx = req.addr[MEM_IDX_BITS+1:2];

  assign resp_xfer = resp_val & resp_rdy;
  assign req_rdy   = !resp_val | resp_rdy;  // Buffer free or freeing
  assign req_xfer  = req_val & req_rdy;

  //----------------------------------------------------------------------
  // Array
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= '0;  // Starts zeroed
    end else if (req_xfer && req.write) begin
      mem[idx] <= req.data;
    end
  end

  //----------------------------------------------------------------------
  // Response buffer
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      resp_val <= 1'b0;
    else if (req_xfer)
      resp_val <= 1'b1;  // New response replaces the one taken
    else if (resp_xfer)
      resp_val <= 1'b0;
  end

  // Read sees the old word, write echoes its data
  always_ff @(posedge clk) begin
    if (req_xfer)
      resp_data <= req.write ? req.data : mem[idx];
  end

  assign resp.data = resp_data;

endmodule

//--- logic/load_store_unit.sv
// Load/store unit
// Two-stage pipeline: stage 1 forms the address and sends one word
// request, stage 2 holds the tags until the memory response arrives and
// pairs them into the writeback message

`timescale 1ns/10ps

module load_store_unit import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // From issue queue
  input  logic       d_val,
  output logic       d_rdy,
  input  issue_msg_t d_msg,

  // Memory request
  output logic       mem_req_val,
  input  logic       mem_req_rdy,
  output mem_req_t   mem_req,

  // Memory response
  input  logic       mem_resp_val,
  output logic       mem_resp_rdy,
  input  mem_resp_t  mem_resp,

  // Writeback
  output logic       wb_val,
  input  logic       wb_rdy,
  output wb_msg_t    wb_msg
);

  // Tags that wait in stage 2 for the response
  typedef struct packed {
    word_t pc;
    seq_t  seq_num;
    areg_t waddr;
    preg_t preg;
    preg_t ppreg;
    logic  wen;
  } s2_tags_t;

  logic       s1_val;
  issue_msg_t s1_msg;
  logic       d_xfer;
  logic       req_xfer;   // Stage 1 to stage 2 move
  word_t      addr;

  logic       s2_val;
  logic       s2_rdy;
  s2_tags_t   s2_tags;
  logic       wb_xfer;

  assign d_xfer   = d_val & d_rdy;
  assign req_xfer = mem_req_val & mem_req_rdy;
  assign wb_xfer  = wb_val & wb_rdy;

  //----------------------------------------------------------------------
  // Stage 1: request
  //----------------------------------------------------------------------

  // Empty, or draining into stage 2 this cycle
  assign d_rdy = !s1_val | (s2_rdy & mem_req_rdy);

  always_ff @(posedge clk) begin
    if (rst)
      s1_val <= 1'b0;
    else if (d_xfer)
      s1_val <= 1'b1;   // Refill wins over drain
    else if (req_xfer)
      s1_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (d_xfer)
      s1_msg <= d_msg;
  end

  assign addr = s1_msg.op1 + s1_msg.op2;  // Wraps at 32 bits

  // Request only goes out when stage 2 has room for the tags
  assign mem_req_val   = s1_val & s2_rdy;
  assign mem_req.write = (s1_msg.uop == UOP_SW);
  assign mem_req.addr  = addr;
  assign mem_req.data  = s1_msg.store_data;

  //----------------------------------------------------------------------
  // Stage 2: response
  //----------------------------------------------------------------------

  // Room when empty or when the held result leaves now
  assign s2_rdy = !s2_val | (wb_rdy & mem_resp_val);

  always_ff @(posedge clk) begin
    if (rst)
      s2_val <= 1'b0;
    else if (req_xfer)
      s2_val <= 1'b1;
    else if (wb_xfer)
      s2_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      s2_tags.pc      <= s1_msg.pc;
      s2_tags.seq_num <= s1_msg.seq_num;
      s2_tags.waddr   <= s1_msg.waddr;
      s2_tags.preg    <= s1_msg.preg;
      s2_tags.ppreg   <= s1_msg.ppreg;
      s2_tags.wen     <= (s1_msg.uop == UOP_LW);  // Stores write no reg
    end
  end

  // Response and tags leave together
  assign wb_val       = s2_val & mem_resp_val;
  assign mem_resp_rdy = s2_val & wb_rdy;

  assign wb_msg.pc      = s2_tags.pc;
  assign wb_msg.seq_num = s2_tags.seq_num;
  assign wb_msg.waddr   = s2_tags.waddr;
  assign wb_msg.preg    = s2_tags.preg;
  assign wb_msg.ppreg   = s2_tags.ppreg;
  assign wb_msg.wen     = s2_tags.wen;
  assign wb_msg.wdata   = mem_resp.data;  // Store echoes its data

endmodule

//--- logic/lsu_issue_queue.sv
// Issue queue
// Four-entry circular FIFO that decouples dispatch from the load/store
// pipeline. Ready depends only on occupancy

`timescale 1ns/10ps

module lsu_issue_queue import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       in_val,
  output logic       in_rdy,
  input  issue_msg_t in_msg,

  output logic       out_val,
  input  logic       out_rdy,
  output issue_msg_t out_msg
);

  typedef logic [$clog2(IQ_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(IQ_DEPTH+1)-1:0] cnt_t;  // Needs to reach IQ_DEPTH

  issue_msg_t entries [IQ_DEPTH];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  cnt_t       count;
  logic       push;
  logic       pop;

  //----------------------------------------------------------------------
  // Handshakes
  //----------------------------------------------------------------------

  assign in_rdy  = (count != cnt_t'(IQ_DEPTH));  // Low only when full
  assign out_val = (count != '0);
  assign out_msg = entries[rd_ptr];               // Head entry

  assign push = in_val & in_rdy;
  assign pop  = out_val & out_rdy;

  //----------------------------------------------------------------------
  // Pointers and occupancy
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + cnt_t'(push) - cnt_t'(pop);  // Push and pop cancel
    end
  end

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    if (push)
      entries[wr_ptr] <= in_msg;
  end

endmodule

//--- logic/lsu_pkg.sv
// LSU package
// Shared widths, micro-op encoding and channel message formats for the
// memory execute pipeline

package lsu_pkg;

  //----------------------------------------------------------------------
  // Widths
  //----------------------------------------------------------------------

  localparam int SEQ_BITS     = 6;    // Reorder sequence number
  localparam int PREG_BITS    = 6;    // Physical register index
  localparam int MEM_WORDS    = 256;  // Data memory depth
  localparam int MEM_IDX_BITS = 8;    // Word index into data memory
  localparam int IQ_DEPTH     = 4;    // Issue queue entries

  typedef logic [31:0]             word_t;
  typedef logic [SEQ_BITS-1:0]     seq_t;
  typedef logic [PREG_BITS-1:0]    preg_t;
  typedef logic [4:0]              areg_t;     // Architectural reg
  typedef logic [MEM_IDX_BITS-1:0] mem_idx_t;

  // Only word load and store survive
  typedef enum logic {
    UOP_LW = 1'b0,
    UOP_SW = 1'b1
  } uop_t;

  //----------------------------------------------------------------------
  // Channel messages
  //----------------------------------------------------------------------

  typedef struct packed {
    word_t pc;
    seq_t  seq_num;
    word_t op1;         // Base
    word_t op2;         // Offset
    word_t store_data;  // Don't care for loads
    areg_t waddr;
    preg_t preg;
    preg_t ppreg;       // Previous mapping of waddr
    uop_t  uop;
  } issue_msg_t;

  typedef struct packed {
    logic  write;
    word_t addr;  // Byte address, low bits ignored
    word_t data;
  } mem_req_t;

  typedef struct packed {
    word_t data;
  } mem_resp_t;

  typedef struct packed {
    word_t pc;
    seq_t  seq_num;
    areg_t waddr;
    preg_t preg;
    preg_t ppreg;
    logic  wen;    // Set for loads only
    word_t wdata;
  } wb_msg_t;

endpackage

//--- logic/lsu_top.sv
// Memory execute pipeline top
// Issue queue feeding the load/store unit, which talks to the data memory

`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       issue_val,
  output logic       issue_rdy,
  input  issue_msg_t issue_msg,

  output logic       wb_val,
  input  logic       wb_rdy,
  output wb_msg_t    wb_msg
);

  // Queue head to unit
  logic       iq_val;
  logic       iq_rdy;
  issue_msg_t iq_msg;

  // Unit to memory
  logic       mem_req_val;
  logic       mem_req_rdy;
  mem_req_t   mem_req;
  logic       mem_resp_val;
  logic       mem_resp_rdy;
  mem_resp_t  mem_resp;

  lsu_issue_queue u_issue_queue (
    .clk     (clk),
    .rst     (rst),
    .in_val  (issue_val),
    .in_rdy  (issue_rdy),
    .in_msg  (issue_msg),
    .out_val (iq_val),
    .out_rdy (iq_rdy),
    .out_msg (iq_msg)
  );

  load_store_unit u_lsu (
    .clk          (clk),
    .rst          (rst),
    .d_val        (iq_val),
    .d_rdy        (iq_rdy),
    .d_msg        (iq_msg),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_resp     (mem_resp),
    .wb_val       (wb_val),
    .wb_rdy       (wb_rdy),
    .wb_msg       (wb_msg)
  );

  data_mem u_mem (
    .clk      (clk),
    .rst      (rst),
    .req_val  (mem_req_val),
    .req_rdy  (mem_req_rdy),
    .req      (mem_req),
    .resp_val (mem_resp_val),
    .resp_rdy (mem_resp_rdy),
    .resp     (mem_resp)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and checks the log

set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module lsu_tb \
  -f all.f \
  -o lsu_sim

# Simulation output goes to the console and to the log
./obj_dir/lsu_sim | tee sim.log

# Result comes from the log, not from the exit status
grep -q "ALL CHECKS PASSED" sim.log

//--- testbench/lsu_tb.sv
// LSU testbench
// Drives load/store traffic into the memory pipeline, predicts every
// writeback from a word model and compares in arrival order

`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

  localparam int TOTAL_OPS      = 144;                  // Sum over all tests
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_OPS + 200;
  localparam int RDY_HIGH = 0;
  localparam int RDY_LOW  = 1;
  localparam int RDY_RAND = 2;

  logic       clk = 1'b0;
  logic       rst;
  logic       issue_val;
  logic       issue_rdy;
  issue_msg_t issue_msg;
  logic       wb_val;
  logic       wb_rdy = 1'b1;
  wb_msg_t    wb_msg;

  word_t   ref_mem [MEM_WORDS];  // Model of the data memory
  wb_msg_t exp_q [$];            // Expected writebacks in issue order
  seq_t    seq_cnt;
  int      rdy_mode = RDY_HIGH;
  int      cycles = 0;
  int      passes = 0;
  int      errors = 0;           // From the compare process
  int      flow_errors = 0;      // From the stimulus process

  lsu_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .issue_val (issue_val),
    .issue_rdy (issue_rdy),
    .issue_msg (issue_msg),
    .wb_val    (wb_val),
    .wb_rdy    (wb_rdy),
    .wb_msg    (wb_msg)
  );

  always #50 clk = ~clk;  // 100 ns period

  //----------------------------------------------------------------------
  // Reference model and compare
  //----------------------------------------------------------------------

  // Expected writeback for one accepted issue message
  function automatic wb_msg_t predict(input issue_msg_t m);
    wb_msg_t w;
    word_t   a;
    a         = m.op1 + m.op2;  // Wraps at 32 bits
    w.pc      = m.pc;
    w.seq_num = m.seq_num;
    w.waddr   = m.waddr;
    w.preg    = m.preg;
    w.ppreg   = m.ppreg;
    if (m.uop == UOP_SW) begin
      ref_mem[a[9:2]] = m.store_data;  // Bits above 9 alias
      w.wen   = 1'b0;
      w.wdata = m.store_data;
    end else begin
      w.wen   = 1'b1;
      w.wdata = ref_mem[a[9:2]];
    end
    return w;
  endfunction

  function automatic void check_field(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[ERROR] %0t wb_msg.%s expected %h got %h", $time, name, exp, act);
      errors++;
    end else begin
      passes++;
    end
  endfunction

  always @(posedge clk) begin
    wb_msg_t e;
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++)
        ref_mem[i] = '0;
    end else begin
      if (wb_val && wb_rdy) begin
        if (exp_q.size() == 0) begin
          $display("At %0t a writeback arrived with no operation outstanding", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          check_field("pc", e.pc, wb_msg.pc);
          check_field("seq_num", word_t'(e.seq_num), word_t'(wb_msg.seq_num));
          check_field("waddr", word_t'(e.waddr), word_t'(wb_msg.waddr));
          check_field("preg", word_t'(e.preg), word_t'(wb_msg.preg));
          check_field("ppreg", word_t'(e.ppreg), word_t'(wb_msg.ppreg));
          check_field("wen", word_t'(e.wen), word_t'(wb_msg.wen));
          check_field("wdata", e.wdata, wb_msg.wdata);
        end
      end
      // Model updates after the compare in acceptance order
      if (issue_val && issue_rdy)
        exp_q.push_back(predict(issue_msg));
    end
  end

  // Drives wb_rdy from the mode sampled at the edge
  always @(posedge clk) begin
    int mode_now;
    mode_now = rdy_mode;
    #1;
    if (mode_now == RDY_LOW)
      wb_rdy = 1'b0;
    else if (mode_now == RDY_RAND)
      wb_rdy = ($urandom() % 2) == 0;  // About half the time
    else
      wb_rdy = 1'b1;
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d writebacks never arrived", cycles, exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------

  // Holds val and payload until the queue takes it
  task automatic send(input uop_t uop, input word_t op1, input word_t op2, input word_t sd);
    issue_msg_t m;
    m.pc         = $urandom();
    m.seq_num    = seq_cnt;
    m.op1        = op1;
    m.op2        = op2;
    m.store_data = sd;
    m.waddr      = areg_t'($urandom());
    m.preg       = preg_t'($urandom());
    m.ppreg      = preg_t'($urandom());
    m.uop        = uop;
    issue_val    = 1'b1;
    issue_msg    = m;
    do @(posedge clk); while (!issue_rdy);
    #1;
    issue_val = 1'b0;
    seq_cnt   = seq_cnt + 1'b1;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    wait_idle();
    $display("Test %s finished, errors so far %0d", name, errors + flow_errors);
  endtask

  initial begin
    int lat;
    void'($urandom(32'h116d));
    rst       = 1'b1;
    issue_val = 1'b0;
    issue_msg = '0;
    seq_cnt   = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset state, then loads from a cleared memory
    if (issue_rdy !== 1'b1) begin
      $display("[ERROR] %0t issue_rdy expected 1 got %b", $time, issue_rdy);
      flow_errors++;
    end
    if (wb_val !== 1'b0) begin
      $display("[ERROR] %0t wb_val expected 0 got %b", $time, wb_val);
      flow_errors++;
    end
    for (int i = 0; i < 8; i++)
      send(UOP_LW, word_t'(i * 36), 32'h0, 32'h0);
    finish_test("reset_loads");

    // Stores, then loads of the same words
    for (int i = 0; i < 8; i++)
      send(UOP_SW, 32'h40, word_t'(i * 4), $urandom());
    for (int i = 0; i < 8; i++)
      send(UOP_LW, word_t'(i * 4), 32'h40, 32'h0);
    finish_test("store_load");

    // Equal sums, wraparound and aliasing above bit 9
    send(UOP_SW, 32'h100, 32'h20, 32'hcafe_f00d);
    send(UOP_LW, 32'h120, 32'h0, 32'h0);
    send(UOP_LW, 32'hffff_fff0, 32'h130, 32'h0);
    send(UOP_LW, 32'h520, 32'h0, 32'h0);
    send(UOP_LW, 32'habcd_0100, 32'h20, 32'h0);
    finish_test("address_forming");

    // Back-to-back loads with tags and order checked per writeback
    for (int i = 0; i < 8; i++)
      send(UOP_LW, 32'h40, word_t'((7 - i) * 4), 32'h0);
    finish_test("tags_order");

    // Random traffic under random back-pressure
    rdy_mode = RDY_RAND;
    for (int i = 0; i < 100; i++) begin
      send(($urandom() % 2) == 0 ? UOP_LW : UOP_SW,
           ($urandom() & 32'hffff_fc00) | 32'h40, $urandom() & 32'h1c, $urandom());
      if (($urandom() % 4) == 0) begin
        @(posedge clk);  // Idle gap
        #1;
      end
    end
    wait_idle();
    // Long stall where the pipeline holds six and then refuses
    rdy_mode = RDY_LOW;
    @(posedge clk);
    #1;
    for (int i = 0; i < 6; i++)
      send(UOP_LW, 32'h40, word_t'(i * 4), 32'h0);
    repeat (3) @(posedge clk);
    if (issue_rdy !== 1'b0) begin
      $display("[ERROR] %0t issue_rdy expected 0 got %b", $time, issue_rdy);
      flow_errors++;
    end
    #1;
    rdy_mode = RDY_HIGH;
    finish_test("backpressure");

    // Latency from an idle pipeline
    send(UOP_LW, 32'h40, 32'h0, 32'h0);
    lat = 1;
    @(posedge clk);
    while (!wb_val) begin
      @(posedge clk);
      lat++;
    end
    if (lat != 3) begin
      $display("At %0t load latency was %0d cycles instead of 3", $time, lat);
      flow_errors++;
    end
    finish_test("latency");

    $display("Checks passed %0d, errors %0d", passes, errors + flow_errors);
    if (errors + flow_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
